// ==== common/pi1wb_pkg.sv ====
/* Shared widths, operation codes and bus structs for the two-master Wishbone memory system.
   Imported by every RTL module and by the testbench. */

package pi1wb_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ARCH_BITS = 32;
	localparam int SEL_BITS  = ARCH_BITS / 8; // One select bit per byte lane
	localparam int ADDR_BITS = 30;            // Word address, lane bits removed
	localparam int MEM_WORDS = 256;
	localparam int MEM_WAIT  = 2;             // Stall cycles before the slave acks

	typedef logic [ARCH_BITS-1:0] data_t;
	typedef logic [SEL_BITS-1:0]  sel_t;
	typedef logic [ADDR_BITS-1:0] word_addr_t;
	typedef logic [ARCH_BITS-1:0] byte_addr_t;
	typedef logic                 port_id_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operation codes and bridge states
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		PI_NOP = 2'b00,
		PI_WR  = 2'b01,
		PI_RD  = 2'b10,
		PI_RW  = 2'b11 // Atomic swap, returns the old word
	} pi_op_e;

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		SWAP_WR
	} bridge_state_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus bundles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		pi_op_e     op;
		word_addr_t addr;
		data_t      data;
		sel_t       sel;
	} pi_req_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		byte_addr_t addr;
		data_t      data;
		sel_t       sel;
	} wb_req_t;

	typedef struct packed {
		logic  stall;
		logic  ack;
		data_t data;
	} wb_rsp_t;

endpackage

// ==== verilog/pi1_arbiter.sv ====
/* Round-robin arbiter that merges two peripheral ports onto one bridge port.
   The owner of the request in flight gets the completing rdy and its read data. */

`timescale 1ns/1ps

module pi1_arbiter import pi1wb_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_i,

	input  pi_req_t m0_req_i,
	output logic    m0_rdy_o,
	output data_t   m0_data_o,

	input  pi_req_t m1_req_i,
	output logic    m1_rdy_o,
	output data_t   m1_data_o,

	output pi_req_t s_req_o,
	input  logic    s_rdy_i,
	input  data_t   s_data_i
);

	logic     m0_valid;
	logic     m1_valid;
	port_id_t grant;
	port_id_t last_q;  // Port granted most recently
	port_id_t owner_q; // Port whose request is in the bridge
	logic     pend_q;
	logic     accept;

	assign m0_valid = (m0_req_i.op != PI_NOP);
	assign m1_valid = (m1_req_i.op != PI_NOP);

	// While a request is in flight the port is pinned to its owner, so the
	// completion cycle cannot be handed to the other master
	always_comb begin
		if (pend_q) begin
			grant = owner_q;
		end else if (m0_valid && m1_valid) begin
			grant = ~last_q; // Both want it, the one not served last wins
		end else if (m1_valid) begin
			grant = 1'b1;
		end else if (m0_valid) begin
			grant = 1'b0;
		end else begin
			grant = ~last_q;
		end
	end

	assign s_req_o = grant ? m1_req_i : m0_req_i;
	assign accept  = s_rdy_i && (s_req_o.op != PI_NOP);

	assign m0_rdy_o = s_rdy_i && (grant == 1'b0);
	assign m1_rdy_o = s_rdy_i && (grant == 1'b1);

	// Read data goes to both, only the port with rdy high takes it
	assign m0_data_o = s_data_i;
	assign m1_data_o = s_data_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			last_q  <= 1'b1; // Port 0 has priority out of reset
			owner_q <= 1'b0;
			pend_q  <= 1'b0;
		end else if (accept) begin
			last_q  <= grant;
			owner_q <= grant;
			pend_q  <= 1'b1;
		end else if (s_rdy_i) begin
			pend_q  <= 1'b0; // Completed with nothing new behind it
		end
	end

endmodule

// ==== pi1_to_wb4/pi1_to_wb4.sv ====
/* Bridge from the peripheral port to a pipelined Wishbone B4 master.
   Reads and writes take one bus cycle; a swap is a read then a write under one cyc. */

`timescale 1ns/1ps

module pi1_to_wb4 import pi1wb_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_i,

	input  pi_req_t pi_req_i,
	output logic    pi_rdy_o,
	output data_t   pi_data_o,

	output wb_req_t wb_req_o,
	input  wb_rsp_t wb_rsp_i
);

	bridge_state_e state_q;
	wb_req_t       wb_q;
	pi_op_e        op_q;   // Operation of the request in flight
	data_t         swap_q; // Old word read by a swap
	logic          done;
	logic          accept;

	// Byte address from the word address and the lowest selected lane
	function automatic byte_addr_t byte_addr(input word_addr_t addr, input sel_t sel);
		logic [$clog2(SEL_BITS)-1:0] lane;
		lane = '0;
		for (int i = SEL_BITS - 1; i >= 0; i--) begin
			if (sel[i]) begin
				lane = i[$clog2(SEL_BITS)-1:0];
			end
		end
		return {addr, lane};
	endfunction

	// A swap is not finished by its read ack, only by the ack of its write
	always_comb begin
		case (state_q)
			BUSY:    done = wb_rsp_i.ack && (op_q != PI_RW);
			SWAP_WR: done = wb_rsp_i.ack;
			default: done = 1'b0;
		endcase
	end

	assign pi_rdy_o  = (state_q == IDLE) || done;
	assign accept    = pi_rdy_o && (pi_req_i.op != PI_NOP);
	assign pi_data_o = (state_q == SWAP_WR) ? swap_q : wb_rsp_i.data;
	assign wb_req_o  = wb_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= IDLE;
			wb_q.cyc <= 1'b0;
			wb_q.stb <= 1'b0;
		end else if (accept) begin
			state_q <= BUSY;
			wb_q.cyc <= 1'b1;
			wb_q.stb <= 1'b1;
		end else if (pi_rdy_o) begin
			state_q <= IDLE; // Finished, or still idle with nothing asked
			wb_q.cyc <= 1'b0;
			wb_q.stb <= 1'b0;
		end else if (state_q == BUSY && op_q == PI_RW && wb_rsp_i.ack) begin
			state_q <= SWAP_WR;
			wb_q.stb <= 1'b1; // Write half of the swap, cyc stays high
		end else if (!wb_rsp_i.stall) begin
			wb_q.stb <= 1'b0; // Transfer taken by the slave
		end
	end

	// Payload follows the same events but needs no reset
	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_q      <= pi_req_i.op;
			wb_q.we   <= (pi_req_i.op == PI_WR);
			wb_q.addr <= byte_addr(pi_req_i.addr, pi_req_i.sel);
			wb_q.data <= pi_req_i.data;
			wb_q.sel  <= pi_req_i.sel;
		end else if (state_q == BUSY && op_q == PI_RW && wb_rsp_i.ack) begin
			wb_q.we <= 1'b1;
			swap_q  <= wb_rsp_i.data;
		end
	end

endmodule

// ==== verilog/wb4_sram.sv ====
/* Word-organised SRAM behind a pipelined Wishbone B4 slave port.
   Each transfer stalls for a fixed number of cycles, then acks with the addressed word. */

`timescale 1ns/1ps

module wb4_sram import pi1wb_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_i,

	input  wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o
);

	typedef logic [$clog2(MEM_WORDS)-1:0]  mem_idx_t;
	typedef logic [$clog2(MEM_WAIT+1)-1:0] wait_cnt_t;

	data_t     mem [MEM_WORDS];
	logic      busy_q;
	logic      ack_q;
	wait_cnt_t cnt_q;
	logic      take;
	logic      fire; // Last wait cycle, the access happens at this edge
	mem_idx_t  idx_q;
	data_t     wdata_q;
	sel_t      sel_q;
	logic      we_q;
	data_t     rdata_q;
	data_t     merged;

	assign take = wb_req_i.cyc && wb_req_i.stb && !busy_q;
	assign fire = busy_q && (cnt_q == '0);

	// Old word with the selected lanes replaced
	always_comb begin
		for (int b = 0; b < SEL_BITS; b++) begin
			merged[8*b +: 8] = sel_q[b] ? wdata_q[8*b +: 8] : mem[idx_q][8*b +: 8];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			ack_q  <= 1'b0;
			cnt_q  <= '0;
		end else begin
			ack_q <= fire;
			if (fire) begin
				busy_q <= 1'b0;
			end else if (busy_q) begin
				cnt_q <= cnt_q - 1'b1;
			end else if (take) begin
				busy_q <= 1'b1;
				cnt_q  <= wait_cnt_t'(MEM_WAIT - 1);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (take) begin
			idx_q   <= wb_req_i.addr[$clog2(SEL_BITS) +: $clog2(MEM_WORDS)]; // Wraps
			wdata_q <= wb_req_i.data;
			sel_q   <= wb_req_i.sel;
			we_q    <= wb_req_i.we;
		end
		if (fire) begin
			if (we_q) begin
				mem[idx_q] <= merged;
			end
			rdata_q <= we_q ? merged : mem[idx_q];
		end
	end

	assign wb_rsp_o.stall = busy_q;
	assign wb_rsp_o.ack   = ack_q;
	assign wb_rsp_o.data  = rdata_q;

endmodule

// ==== verilog/pi1wb_top.sv ====
/* Two peripheral masters sharing one Wishbone SRAM.
   Chain is arbiter, then bridge, then memory. */

`timescale 1ns/1ps

module pi1wb_top import pi1wb_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_i,

	input  pi_req_t m0_req_i,
	output logic    m0_rdy_o,
	output data_t   m0_data_o,

	input  pi_req_t m1_req_i,
	output logic    m1_rdy_o,
	output data_t   m1_data_o
);

	pi_req_t arb_req;
	logic    arb_rdy;
	data_t   arb_data;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	pi1_arbiter i_pi1_arbiter (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.m0_req_i  (m0_req_i),
		.m0_rdy_o  (m0_rdy_o),
		.m0_data_o (m0_data_o),
		.m1_req_i  (m1_req_i),
		.m1_rdy_o  (m1_rdy_o),
		.m1_data_o (m1_data_o),
		.s_req_o   (arb_req),
		.s_rdy_i   (arb_rdy),
		.s_data_i  (arb_data)
	);

	pi1_to_wb4 i_pi1_to_wb4 (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.pi_req_i  (arb_req),
		.pi_rdy_o  (arb_rdy),
		.pi_data_o (arb_data),
		.wb_req_o  (wb_req),
		.wb_rsp_i  (wb_rsp)
	);

	wb4_sram i_wb4_sram (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.wb_req_i (wb_req),
		.wb_rsp_o (wb_rsp)
	);

endmodule

// ==== testbench/pi1wb_sva.sv ====
/* Protocol assertions on the Wishbone link and the two arbiter ports.
   Bound into pi1wb_top from the testbench. */

`timescale 1ns/1ps

module pi1wb_sva import pi1wb_pkg::*; (
	input logic    clk_i,
	input logic    rst_i,
	input wb_req_t wb_req_i,
	input wb_rsp_t wb_rsp_i,
	input logic    m0_rdy_i,
	input logic    m1_rdy_i
);

	stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_req_i.stb |-> wb_req_i.cyc)
		else $error("Wishbone stb is high outside a bus cycle");

	ack_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_rsp_i.ack |-> wb_req_i.cyc)
		else $error("Wishbone ack arrived while cyc was low");

	// The arbiter serves one master per cycle
	one_rdy: assert property (@(posedge clk_i) disable iff (rst_i)
		!(m0_rdy_i && m1_rdy_i))
		else $error("Both peripheral ports signalled rdy in the same cycle");

	stalled_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		(wb_req_i.stb && wb_rsp_i.stall) |=>
		(wb_req_i.stb && $stable({wb_req_i.we, wb_req_i.addr, wb_req_i.data, wb_req_i.sel})))
		else $error("Wishbone request changed while the slave was stalling");

endmodule

// ==== testbench/pi1wb_tb.sv ====
/* Testbench for the two-master Wishbone memory system.
   Plays each line of the case file on both ports and checks the data returned to each. */

`timescale 1ns/1ps

module pi1wb_tb import pi1wb_pkg::*; ();

	localparam int    MAX_CASES       = 64;
	localparam int    WORDS_PER_CASE  = 12;
	localparam int    CASE_WORDS      = MAX_CASES * WORDS_PER_CASE;
	localparam int    RESET_CYCLES    = 5;
	localparam int    CYCLES_PER_CASE = 40;
	localparam string CASE_FILE       = "testbench/pi1wb_cases.txt";

	typedef logic [$clog2(CASE_WORDS)-1:0] word_idx_t;

	logic        clk_i;
	logic        rst_i;
	pi_req_t     m0_req;
	logic        m0_rdy;
	data_t       m0_data;
	pi_req_t     m1_req;
	logic        m1_rdy;
	data_t       m1_data;

	logic [31:0] case_words [CASE_WORDS];
	int          n_cases;
	int          errors;
	int          cycles = 0;
	int          cycle_limit = 0;
	port_id_t    last_grant; // Port accepted most recently
	int          cont_acc [2]; // Contended arbitrations won per port

	pi1wb_top i_pi1wb_top (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.m0_req_i  (m0_req),
		.m0_rdy_o  (m0_rdy),
		.m0_data_o (m0_data),
		.m1_req_i  (m1_req),
		.m1_rdy_o  (m1_rdy),
		.m1_data_o (m1_data)
	);

	bind pi1wb_top pi1wb_sva i_pi1wb_sva (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.wb_req_i (wb_req),
		.wb_rsp_i (wb_rsp),
		.m0_rdy_i (m0_rdy_o),
		.m1_rdy_i (m1_rdy_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			errors = errors + 1;
			$display("Simulation timed out after %0d cycles without finishing the cases", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Case file
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] word_at(input int pos);
		return case_words[word_idx_t'(pos)];
	endfunction

	// Lines end where the enable words stop being 0 or 1
	task automatic load_cases();
		int   base;
		logic scanning;
		for (int i = 0; i < CASE_WORDS; i++) begin
			case_words[word_idx_t'(i)] = {16'hdead, 16'(i)};
		end
		$readmemh(CASE_FILE, case_words);
		n_cases  = 0;
		scanning = 1'b1;
		while (scanning && n_cases < MAX_CASES) begin
			base = n_cases * WORDS_PER_CASE;
			if (word_at(base) <= 32'd1 && word_at(base + 5) <= 32'd1) begin
				n_cases = n_cases + 1;
			end else begin
				scanning = 1'b0;
			end
		end
	endtask

	function automatic pi_req_t make_req(input int idx, input int port);
		pi_req_t     req;
		int          base;
		logic [31:0] op_w;
		logic [31:0] addr_w;
		logic [31:0] sel_w;
		base     = idx * WORDS_PER_CASE + port * 5;
		op_w     = word_at(base + 1);
		addr_w   = word_at(base + 2);
		sel_w    = word_at(base + 4);
		req.op   = pi_op_e'(op_w[1:0]);
		req.addr = addr_w[ADDR_BITS-1:0];
		req.data = word_at(base + 3);
		req.sel  = sel_w[SEL_BITS-1:0];
		if (word_at(base) != 32'd1) begin
			req.op = PI_NOP; // Port sits this line out
		end
		return req;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One case line on both ports
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_case(input int idx);
		pi_req_t    req [2];
		data_t      exp_data [2];
		data_t      got [2];
		logic [1:0] en;
		logic [1:0] acc;
		logic [1:0] fin;
		logic [1:0] take;
		logic [1:0] rdy;
		logic       contend;
		logic       first_seen;
		port_id_t   p;
		for (int i = 0; i < 2; i++) begin
			p           = port_id_t'(i);
			req[p]      = make_req(idx, i);
			exp_data[p] = word_at(idx * WORDS_PER_CASE + 10 + i);
			en[p]       = (req[p].op != PI_NOP);
		end
		contend    = en[0] && en[1];
		first_seen = 1'b0;
		acc        = ~en;
		fin        = ~en;
		m0_req     = req[0];
		m1_req     = req[1];
		while (fin != 2'b11) begin
			@(negedge clk_i);
			rdy    = {m1_rdy, m0_rdy};
			got[0] = m0_data;
			got[1] = m1_data;
			assert (rdy != 2'b11) else begin
				errors = errors + 1;
				$display("CHECK FAILED at %0t: both rdys high in case %0d", $time, idx);
			end
			for (int i = 0; i < 2; i++) begin
				p       = port_id_t'(i);
				take[p] = 1'b0;
				if (acc[p] && !fin[p] && rdy[p]) begin
					fin[p] = 1'b1; // Completion of the accepted request
					assert (got[p] === exp_data[p]) else begin
						errors = errors + 1;
						$display("CHECK FAILED at %0t: case %0d port %0d expected %h got %h",
							$time, idx, i, exp_data[p], got[p]);
					end
				end else if (!acc[p] && rdy[p]) begin
					take[p] = 1'b1; // Request is held, so it is taken at the coming edge
				end
			end
			@(posedge clk_i);
			#1;
			for (int i = 0; i < 2; i++) begin
				p = port_id_t'(i);
				if (take[p]) begin
					acc[p] = 1'b1;
					if (p == 1'b0) begin
						m0_req.op = PI_NOP;
					end else begin
						m1_req.op = PI_NOP;
					end
					if (contend && !first_seen) begin
						first_seen  = 1'b1;
						cont_acc[p] = cont_acc[p] + 1;
						assert (p == ~last_grant) else begin
							errors = errors + 1;
							$display("CHECK FAILED at %0t: case %0d port %0d won out of turn",
								$time, idx, i);
						end
					end
					last_grant = p;
				end
			end
		end
	endtask

	initial begin
		errors      = 0;
		last_grant  = 1'b1; // Port 0 goes first out of reset
		cont_acc[0] = 0;
		cont_acc[1] = 0;
		rst_i       = 1'b1;
		m0_req      = '0;
		m1_req      = '0;
		load_cases();
		cycle_limit = RESET_CYCLES + 4 + n_cases * CYCLES_PER_CASE;
		repeat (RESET_CYCLES) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		@(negedge clk_i);
		assert (m0_rdy === 1'b1 && m1_rdy === 1'b0) else begin
			errors = errors + 1;
			$display("CHECK FAILED at %0t: after reset rdy is %b/%b, port 0 should own it",
				$time, m0_rdy, m1_rdy);
		end
		if (n_cases == 0) begin
			errors = errors + 1;
			$display("No case lines could be read from %s", CASE_FILE);
		end
		@(posedge clk_i);
		#1;
		for (int i = 0; i < n_cases; i++) begin
			run_case(i);
		end
		// Round-robin priority has to hand contended lines to both ports over the run
		assert (cont_acc[0] > 0 && cont_acc[1] > 0) else begin
			errors = errors + 1;
			$display("CHECK FAILED at %0t: contended wins per port are %0d and %0d",
				$time, cont_acc[0], cont_acc[1]);
		end
		$display("Ran %0d case lines, %0d errors", n_cases, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== pi1wb.f ====
common/pi1wb_pkg.sv
verilog/pi1_arbiter.sv
pi1_to_wb4/pi1_to_wb4.sv
verilog/wb4_sram.sv
verilog/pi1wb_top.sv
testbench/pi1wb_sva.sv
testbench/pi1wb_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the pi1wb testbench with Verilator, runs it and checks the log for a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pi1wb_tb -f pi1wb.f -o pi1wb_sim \
	> build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/pi1wb_sim > sim.log 2>&1 || echo "Simulator returned a failing status" >> sim.log
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0

// ==== testbench/pi1wb_cases.txt ====
// Columns: en0 op0 addr0 data0 sel0  en1 op1 addr1 data1 sel1  exp0 exp1 (all hex)
// op is 0 none, 1 write, 2 read, 3 swap; exp is the word returned when rdy comes back
// First write and read back on each port
1 1 010 11223344 f  0 0 0 0 0  11223344 0
1 2 010 00000000 f  0 0 0 0 0  11223344 0
0 0 0 0 0  1 1 020 a5a5a5a5 f  0 a5a5a5a5
0 0 0 0 0  1 2 020 00000000 f  0 a5a5a5a5
// Byte-lane writes followed by full reads
1 1 010 ccddeeff 4  0 0 0 0 0  11dd3344 0
1 2 010 00000000 f  0 0 0 0 0  11dd3344 0
0 0 0 0 0  1 1 020 12345678 3  0 a5a55678
0 0 0 0 0  1 2 020 00000000 f  0 a5a55678
1 1 010 9900aabb 9  0 0 0 0 0  99dd33bb 0
1 2 010 00000000 f  0 0 0 0 0  99dd33bb 0
// Swap returns the old word, the read after it sees the new one
1 3 010 deadbeef f  0 0 0 0 0  99dd33bb 0
1 2 010 00000000 f  0 0 0 0 0  deadbeef 0
0 0 0 0 0  1 3 020 cafef00d f  0 a5a55678
0 0 0 0 0  1 2 020 00000000 f  0 cafef00d
// Both ports in every line
1 1 030 00000030 f  1 1 031 00000031 f  00000030 00000031
1 2 031 00000000 f  1 2 030 00000000 f  00000031 00000030
1 1 040 01010101 f  1 1 041 02020202 f  01010101 02020202
1 3 041 0a0a0a0a f  1 2 040 00000000 f  02020202 01010101
1 2 041 00000000 f  1 2 041 00000000 f  0a0a0a0a 0a0a0a0a
1 1 040 0000ff00 2  1 2 031 00000000 f  0101ff01 00000031
1 2 040 00000000 f  1 2 031 00000000 f  0101ff01 00000031
// Addresses wrap modulo the memory size
1 1 160 60606060 f  0 0 0 0 0  60606060 0
0 0 0 0 0  1 2 060 00000000 f  0 60606060
0 0 0 0 0  1 1 3fffff61 61616161 f  0 61616161
1 2 061 00000000 f  0 0 0 0 0  61616161 0
1 2 260 00000000 f  0 0 0 0 0  60606060 0
1 3 1061 77777777 f  1 2 160 00000000 f  61616161 60606060
1 2 061 00000000 f  1 2 161 00000000 f  77777777 77777777
// Swaps from both ports, then aliased reads
1 3 030 13131313 f  1 3 031 14141414 f  00000030 00000031
1 2 030 00000000 f  1 2 031 00000000 f  13131313 14141414
0 0 0 0 0  1 2 1030 00000000 f  0 13131313
1 2 3fffff31 00000000 f  0 0 0 0 0  14141414 0
